/* Bender.yml */
package:
  name: tqv_periph

sources:
  - include_dirs:
      - .
    files:
      - tqv_periph_pkg.sv
      - periph_addr_decode.sv
      - read_return_buffer.sv
      - gpio_block.sv
      - pin_func_mux.sv
      - tqv_periph_interconnect.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tqv_periph.sv

/* gpio_block.sv */
/*
 * GPIO registers living in user slot 1.
 * Offset 0x00 is the output byte, 0x04 reads the input pins, and
 * 0x20..0x3c hold one 5-bit function select per output pin.
 * Reads are combinational and always ready, writes land on the next edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_params.svh"

module gpio_block (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      i_sel,
    input  tqv_periph_pkg::slot_req_t                 i_req,
    input  logic [`TQV_PINS-1:0]                      i_ui_in,
    output tqv_periph_pkg::user_rsp_t                 o_rsp,
    output logic [`TQV_PINS-1:0][`TQV_FUNC_SEL_W-1:0] o_func_sel
);

    localparam int SEL_IDX_W = $clog2(`TQV_PINS);
    // Offset bits that pick one of the word-spaced select registers
    localparam logic [`TQV_OFFSET_W-1:0] SEL_IDX_MASK = `TQV_OFFSET_W'((`TQV_PINS - 1) << 2);

    logic [`TQV_PINS-1:0]                      gpio_out_q;
    logic [`TQV_PINS-1:0][`TQV_FUNC_SEL_W-1:0] func_sel_q;
    logic                                      wr_en;
    logic                                      out_hit;
    logic                                      in_hit;
    logic                                      sel_hit;
    logic [SEL_IDX_W-1:0]                      sel_idx;

    assign wr_en   = i_sel && (i_req.write_size != tqv_periph_pkg::SIZE_NONE);
    assign out_hit = (i_req.offset == `TQV_GPIO_OUT_OFS);
    assign in_hit  = (i_req.offset == `TQV_GPIO_IN_OFS);
    assign sel_hit = ((i_req.offset & ~SEL_IDX_MASK) == `TQV_GPIO_SEL_BASE);
    assign sel_idx = i_req.offset[2 +: SEL_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
            // Pins 0-1 start on the UART slot, the rest on GPIO
            for (int p = 0; p < `TQV_PINS; p++) begin
                func_sel_q[p] <= (p < 2) ? `TQV_FUNC_SEL_W'(`TQV_SLOT_UART)
                                         : `TQV_FUNC_SEL_W'(`TQV_SLOT_GPIO);
            end
        end else if (wr_en) begin
            if (out_hit) begin
                gpio_out_q <= i_req.wdata[`TQV_PINS-1:0];
            end
            if (sel_hit) begin
                func_sel_q[sel_idx] <= i_req.wdata[`TQV_FUNC_SEL_W-1:0];
            end
        end
    end

    always_comb begin
        o_rsp.rdata = '0;
        if (out_hit) begin
            o_rsp.rdata = {{(`TQV_DATA_W-`TQV_PINS){1'b0}}, gpio_out_q};
        end else if (in_hit) begin
            o_rsp.rdata = {{(`TQV_DATA_W-`TQV_PINS){1'b0}}, i_ui_in};
        end else if (sel_hit) begin
            o_rsp.rdata = {{(`TQV_DATA_W-`TQV_FUNC_SEL_W){1'b0}}, func_sel_q[sel_idx]};
        end
        o_rsp.ready = 1'b1;
        o_rsp.uo    = gpio_out_q;
    end

    assign o_func_sel = func_sel_q;

endmodule

`default_nettype wire

/* periph_addr_decode.sv */
/*
 * Combinational address decode for the peripheral interconnect.
 * Produces a one-hot user slot select and a one-hot simple slot write
 * strobe, and muxes the selected slot's read data and ready back.
 * Simple slots are byte wide and always ready.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_params.svh"

module periph_addr_decode (
    input  tqv_periph_pkg::bus_req_t                           i_bus,
    input  tqv_periph_pkg::user_rsp_t   [`TQV_USER_SLOTS-1:0]   i_user_rsp,
    input  tqv_periph_pkg::simple_rsp_t [`TQV_SIMPLE_SLOTS-1:0] i_simple_rsp,
    output logic [`TQV_USER_SLOTS-1:0]                         o_user_sel,
    output logic [`TQV_SIMPLE_SLOTS-1:0]                       o_simple_wr,
    output logic [`TQV_DATA_W-1:0]                             o_peri_rdata,
    output logic                                               o_peri_ready
);

    localparam int USER_IDX_W   = $clog2(`TQV_USER_SLOTS);
    localparam int SIMPLE_IDX_W = $clog2(`TQV_SIMPLE_SLOTS);
    // Simple slots occupy 16 bytes each
    localparam int SIMPLE_IDX_LSB = 4;

    logic                    is_simple;
    logic                    write_req;
    logic [USER_IDX_W-1:0]   user_idx;
    logic [SIMPLE_IDX_W-1:0] simple_idx;

    // Top address bit splits user space from simple space
    assign is_simple  = i_bus.addr[`TQV_ADDR_W-1];
    assign write_req  = (i_bus.write_size != tqv_periph_pkg::SIZE_NONE);
    assign user_idx   = i_bus.addr[`TQV_OFFSET_W +: USER_IDX_W];
    assign simple_idx = i_bus.addr[SIMPLE_IDX_LSB +: SIMPLE_IDX_W];

    always_comb begin
        o_user_sel  = '0;
        o_simple_wr = '0;

        if (is_simple) begin
            o_simple_wr[simple_idx] = write_req;
            o_peri_rdata = {{(`TQV_DATA_W-8){1'b0}}, i_simple_rsp[simple_idx].rdata};
            o_peri_ready = 1'b1;
        end else begin
            o_user_sel[user_idx] = 1'b1;
            o_peri_rdata = i_user_rsp[user_idx].rdata;
            o_peri_ready = i_user_rsp[user_idx].ready;
        end
    end

endmodule

`default_nettype wire

/* pin_func_mux.sv */
/*
 * Output pin multiplexer.
 * Each pin takes its own bit from the slot named by its function select:
 * bit 4 picks simple or user space, bits 3:0 pick the slot number.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_params.svh"

module pin_func_mux (
    input  logic [`TQV_PINS-1:0][`TQV_FUNC_SEL_W-1:0] i_func_sel,
    input  logic [`TQV_USER_SLOTS-1:0][`TQV_PINS-1:0]  i_user_uo,
    input  logic [`TQV_SIMPLE_SLOTS-1:0][`TQV_PINS-1:0] i_simple_uo,
    output logic [`TQV_PINS-1:0]                      o_uo_out
);

    localparam int SLOT_W = `TQV_FUNC_SEL_W - 1;

    always_comb begin
        logic [SLOT_W-1:0] slot;

        for (int i = 0; i < `TQV_PINS; i++) begin
            slot = i_func_sel[i][SLOT_W-1:0];
            if (i_func_sel[i][SLOT_W]) begin
                o_uo_out[i] = i_simple_uo[slot][i];
            end else begin
                o_uo_out[i] = i_user_uo[slot][i];
            end
        end
    end

endmodule

`default_nettype wire

/* read_return_buffer.sv */
/*
 * Registered read return path towards the core.
 * Captures the first ready read result and holds it until the core
 * flags read complete, so slots need not hold their data themselves.
 * While ready is registered the read size seen by slots is masked to
 * idle, which stops a second read of the same location.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_params.svh"

module read_return_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  tqv_periph_pkg::access_size_e  i_read_size,
    input  tqv_periph_pkg::access_size_e  i_write_size,
    input  logic [`TQV_DATA_W-1:0]        i_peri_rdata,
    input  logic                          i_peri_ready,
    input  logic                          i_read_complete,
    output logic [`TQV_DATA_W-1:0]        o_rdata,
    output logic                          o_ready,
    output tqv_periph_pkg::access_size_e  o_read_size_masked
);

    logic                   read_req;
    logic                   capture;
    logic                   hold_q;
    logic                   ready_q;
    logic [`TQV_DATA_W-1:0] rdata_q;

    assign read_req = (i_read_size != tqv_periph_pkg::SIZE_NONE);
    // Only the first ready cycle of a read is captured
    assign capture  = read_req && i_peri_ready && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && i_peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= i_peri_rdata;
        end
    end

    assign o_rdata = rdata_q;
    // Writes complete in the cycle they are issued
    assign o_ready = ready_q || (i_write_size != tqv_periph_pkg::SIZE_NONE);
    assign o_read_size_masked = ready_q ? tqv_periph_pkg::SIZE_NONE : i_read_size;

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
tqv_periph_pkg.sv
periph_addr_decode.sv
read_return_buffer.sv
gpio_block.sv
pin_func_mux.sv
tqv_periph_interconnect.sv
tb_tqv_periph.sv

/* tb_tqv_periph.sv */
/*
 * Directed testbench for the peripheral interconnect.
 * Models external user slots 2-15 and simple slots 0-15, then runs one
 * task per behavior: reset state, GPIO, slot reads, write decode,
 * pin function selects and read masking while a result is buffered.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_params.svh"

module tb_tqv_periph;

    localparam int CLK_PERIOD      = 100;
    // About 60 reads of up to 8 cycles plus 55 writes of 2, with wide margin
    localparam int MAX_CYCLES      = 2000;
    localparam int READ_WAIT_LIMIT = 10;
    localparam logic [`TQV_ADDR_W-1:0] GPIO_BASE = 11'h040;

    logic                                          clk;
    logic                                          rst_n;
    tqv_periph_pkg::bus_req_t                      bus;
    logic                                          read_complete;
    logic [`TQV_PINS-1:0]                          ui_in;
    tqv_periph_pkg::user_rsp_t [`TQV_USER_SLOTS-1:2] user_rsp;
    tqv_periph_pkg::simple_rsp_t [`TQV_SIMPLE_SLOTS-1:0] simple_rsp;
    logic [`TQV_DATA_W-1:0]                        rdata;
    logic                                          ready;
    logic [`TQV_PINS-1:0]                          uo_out;
    tqv_periph_pkg::slot_req_t                     slot_req;
    logic [`TQV_USER_SLOTS-1:0]                    user_sel;
    logic [`TQV_SIMPLE_SLOTS-1:0]                  simple_wr;
    logic [3:0]                                    simple_addr;
    logic [7:0]                                    simple_wdata;

    // Peripheral model state
    logic [15:0] model_lo;
    int          model_delay;
    int          wait_cnt = 0;
    int          reads_seen = 0;
    logic        model_active;
    logic        model_ready;

    // Expected register contents
    logic [`TQV_PINS-1:0][`TQV_FUNC_SEL_W-1:0] sel_mirror;
    logic [`TQV_PINS-1:0]                      gpio_mirror;

    logic [31:0] rng_state;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          cycle_cnt = 0;

    tqv_periph_interconnect uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_bus           (bus),
        .i_read_complete (read_complete),
        .i_ui_in         (ui_in),
        .i_user_rsp      (user_rsp),
        .i_simple_rsp    (simple_rsp),
        .o_rdata         (rdata),
        .o_ready         (ready),
        .o_uo_out        (uo_out),
        .o_slot_req      (slot_req),
        .o_user_sel      (user_sel),
        .o_simple_wr     (simple_wr),
        .o_simple_addr   (simple_addr),
        .o_simple_wdata  (simple_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // User slot k answers with its number and offset, after model_delay cycles
    assign model_active = (|user_sel[`TQV_USER_SLOTS-1:2])
                          && (slot_req.read_size != tqv_periph_pkg::SIZE_NONE);
    assign model_ready  = model_active && (wait_cnt >= model_delay);

    for (genvar k = 2; k < `TQV_USER_SLOTS; k++) begin : g_user_model
        assign user_rsp[k].rdata = {4'hc, 4'(k), 2'b00, slot_req.offset, model_lo};
        assign user_rsp[k].ready = user_sel[k] && model_ready;
        assign user_rsp[k].uo    = {4'(k), 4'(k)};
    end

    for (genvar j = 0; j < `TQV_SIMPLE_SLOTS; j++) begin : g_simple_model
        assign simple_rsp[j].rdata = 8'h40 + 8'(j);
        assign simple_rsp[j].uo    = ~8'(j);
    end

    always @(posedge clk) begin
        if (!rst_n || !model_active) begin
            wait_cnt <= 0;
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
        // Every accepted read at a model
        if (model_ready) begin
            reads_seen <= reads_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Pin value expected from the select registers and the slot models
    function automatic logic [7:0] expected_uo();
        logic [7:0] res;
        logic [7:0] src;
        logic [4:0] s;
        for (int p = 0; p < `TQV_PINS; p++) begin
            s = sel_mirror[p];
            if (s[4]) begin
                src = ~{4'b0, s[3:0]};
            end else if (s[3:0] == 4'd0) begin
                src = 8'h00;
            end else if (s[3:0] == 4'd1) begin
                src = gpio_mirror;
            end else begin
                src = {s[3:0], s[3:0]};
            end
            res[p] = src[p];
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_cond(input logic cond, input string msg);
        check_cnt++;
        assert (cond) else begin
            $display("Check failed at %0t: %s", $time, msg);
            err_cnt++;
        end
    endtask

    task automatic drive_idle();
        bus.addr       = '0;
        bus.wdata      = '0;
        bus.write_size = tqv_periph_pkg::SIZE_NONE;
        bus.read_size  = tqv_periph_pkg::SIZE_NONE;
    endtask

    // Word write, checking same-cycle ready, the decoded strobe and the slot fields
    task automatic do_write(input logic [10:0] addr, input logic [31:0] data);
        logic [15:0] exp_user;
        logic [15:0] exp_simple;
        exp_user   = '0;
        exp_simple = '0;
        if (addr[10]) begin
            exp_simple[addr[7:4]] = 1'b1;
        end else begin
            exp_user[addr[9:6]] = 1'b1;
        end
        @(negedge clk);
        bus.addr       = addr;
        bus.wdata      = data;
        bus.write_size = tqv_periph_pkg::SIZE_WORD;
        bus.read_size  = tqv_periph_pkg::SIZE_NONE;
        #(CLK_PERIOD/4);
        check_value("o_ready", ready, 1);
        check_value("o_user_sel", user_sel, exp_user);
        check_value("o_simple_wr", simple_wr, exp_simple);
        check_value("o_slot_req.offset", slot_req.offset, addr[5:0]);
        check_value("o_slot_req.wdata", slot_req.wdata, data);
        check_value("o_slot_req.write_size", 32'(slot_req.write_size),
                    32'(tqv_periph_pkg::SIZE_WORD));
        check_value("o_simple_addr", simple_addr, addr[3:0]);
        check_value("o_simple_wdata", simple_wdata, data[7:0]);
        @(negedge clk);
        drive_idle();
    endtask

    // Word read with model delay and data, then a held result until read complete
    task automatic do_read(input logic [10:0] addr, input int delay,
                           input logic [15:0] lo, output logic [31:0] data);
        int          cycles;
        int          exp_lat;
        int          seen_before;
        logic        ext_user;
        logic [31:0] held;
        ext_user = !addr[10] && (addr[9:6] >= 4'd2);
        exp_lat  = ext_user ? delay + 1 : 1;
        @(negedge clk);
        model_delay   = delay;
        model_lo      = lo;
        seen_before   = reads_seen;
        bus.addr      = addr;
        bus.read_size = tqv_periph_pkg::SIZE_WORD;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ready && cycles < READ_WAIT_LIMIT);
        check_cond(ready, "read never returned o_ready");
        check_value("read latency", cycles, exp_lat);
        check_value("o_slot_req.read_size", 32'(slot_req.read_size),
                    32'(tqv_periph_pkg::SIZE_NONE));
        held = rdata;
        model_lo = ~lo;
        // Core drops the read only after the edge that follows ready
        @(negedge clk);
        check_value("o_rdata", rdata, held);
        drive_idle();
        @(negedge clk);
        check_value("o_rdata", rdata, held);
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        if (ext_user) begin
            check_value("model read count", reads_seen - seen_before, 1);
        end
        data = held;
    endtask

    task automatic test_reset_state();
        check_value("o_ready", ready, 0);
        check_value("o_uo_out", uo_out, expected_uo());
    endtask

    task automatic test_gpio();
        logic [31:0] data;
        rng_state = xorshift32(rng_state);
        gpio_mirror = rng_state[7:0];
        do_write(GPIO_BASE | `TQV_GPIO_OUT_OFS, {24'h0, gpio_mirror});
        do_read(GPIO_BASE | `TQV_GPIO_OUT_OFS, 0, 16'h0, data);
        check_value("gpio out readback", data, {24'h0, gpio_mirror});
        @(negedge clk);
        ui_in = rng_state[15:8];
        do_read(GPIO_BASE | `TQV_GPIO_IN_OFS, 0, 16'h0, data);
        check_value("gpio in readback", data, {24'h0, ui_in});
        check_value("o_uo_out", uo_out, expected_uo());
    endtask

    task automatic test_slot_reads();
        logic [31:0] data;
        logic [5:0]  ofs;
        for (int k = 0; k < `TQV_USER_SLOTS; k++) begin
            if (k != `TQV_SLOT_GPIO) begin
                rng_state = xorshift32(rng_state);
                ofs = rng_state[5:0];
                do_read({1'b0, 4'(k), ofs}, int'(rng_state[9:8]), rng_state[31:16], data);
                check_value("user slot data", data,
                            (k == 0) ? 32'h0 : {4'hc, 4'(k), 2'b00, ofs, rng_state[31:16]});
            end
        end
        for (int j = 0; j < `TQV_SIMPLE_SLOTS; j++) begin
            rng_state = xorshift32(rng_state);
            do_read({3'b100, 4'(j), rng_state[3:0]}, 0, 16'h0, data);
            check_value("simple slot data", data, 32'h40 + 32'(j));
        end
    endtask

    task automatic test_write_decode();
        for (int k = 2; k < `TQV_USER_SLOTS; k++) begin
            rng_state = xorshift32(rng_state);
            do_write({1'b0, 4'(k), rng_state[5:0]}, rng_state);
        end
        for (int j = 0; j < `TQV_SIMPLE_SLOTS; j++) begin
            rng_state = xorshift32(rng_state);
            do_write({3'b100, 4'(j), rng_state[3:0]}, rng_state);
        end
    endtask

    task automatic test_func_select();
        logic [31:0] data;
        logic [4:0]  sel;
        logic [10:0] addr;
        // Round 0 uses simple slots, round 1 user slots, round 2 either
        for (int round = 0; round < 3; round++) begin
            for (int p = 0; p < `TQV_PINS; p++) begin
                rng_state = xorshift32(rng_state);
                sel = rng_state[4:0];
                if (round == 0) begin
                    sel[4] = 1'b1;
                end else if (round == 1) begin
                    sel[4] = 1'b0;
                end
                addr = GPIO_BASE | `TQV_GPIO_SEL_BASE | 11'(p * 4);
                do_write(addr, {27'h0, sel});
                sel_mirror[p] = sel;
                do_read(addr, 0, 16'h0, data);
                check_value("func select readback", data, {27'h0, sel});
            end
            check_value("o_uo_out", uo_out, expected_uo());
        end
    endtask

    task automatic test_read_masking();
        logic [31:0] data;
        for (int d = 0; d < 4; d++) begin
            rng_state = xorshift32(rng_state);
            do_read({1'b0, 4'd5, 6'h08}, d, rng_state[15:0], data);
            check_value("masked read data", data, {4'hc, 4'd5, 2'b00, 6'h08, rng_state[15:0]});
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        read_complete = 1'b0;
        ui_in         = '0;
        model_lo      = '0;
        model_delay   = 0;
        rng_state     = 32'h2ae7_7e4f;
        gpio_mirror   = '0;
        drive_idle();
        for (int p = 0; p < `TQV_PINS; p++) begin
            sel_mirror[p] = (p < 2) ? 5'(`TQV_SLOT_UART) : 5'(`TQV_SLOT_GPIO);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_gpio();
        test_slot_reads();
        test_write_decode();
        test_func_select();
        test_read_masking();

        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tqv_periph_interconnect.sv */
/*
 * Peripheral interconnect top for the TinyQV microcontroller.
 * Connects the core request to 16 user slots and 16 simple slots,
 * with GPIO built in at user slot 1 and slot 0 reserved.
 * User slots 2-15 and all simple slots are external ports.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tqv_periph_params.svh"

module tqv_periph_interconnect (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  tqv_periph_pkg::bus_req_t                           i_bus,
    input  logic                                               i_read_complete,
    input  logic [`TQV_PINS-1:0]                               i_ui_in,
    input  tqv_periph_pkg::user_rsp_t   [`TQV_USER_SLOTS-1:2]   i_user_rsp,
    input  tqv_periph_pkg::simple_rsp_t [`TQV_SIMPLE_SLOTS-1:0] i_simple_rsp,
    output logic [`TQV_DATA_W-1:0]                             o_rdata,
    output logic                                               o_ready,
    output logic [`TQV_PINS-1:0]                               o_uo_out,
    output tqv_periph_pkg::slot_req_t                          o_slot_req,
    output logic [`TQV_USER_SLOTS-1:0]                         o_user_sel,
    output logic [`TQV_SIMPLE_SLOTS-1:0]                       o_simple_wr,
    output logic [3:0]                                         o_simple_addr,
    output logic [7:0]                                         o_simple_wdata
);

    tqv_periph_pkg::user_rsp_t [`TQV_USER_SLOTS-1:0]    user_rsp;
    tqv_periph_pkg::access_size_e                      read_size_masked;
    logic [`TQV_DATA_W-1:0]                            peri_rdata;
    logic                                              peri_ready;
    logic [`TQV_PINS-1:0][`TQV_FUNC_SEL_W-1:0]         func_sel;
    logic [`TQV_USER_SLOTS-1:0][`TQV_PINS-1:0]         user_uo;
    logic [`TQV_SIMPLE_SLOTS-1:0][`TQV_PINS-1:0]       simple_uo;

    // Reserved slot 0 reads as zero and never stalls the core
    assign user_rsp[0].rdata = '0;
    assign user_rsp[0].ready = 1'b1;
    assign user_rsp[0].uo    = '0;
    assign user_rsp[`TQV_USER_SLOTS-1:2] = i_user_rsp;

    // Broadcast request to user slots
    assign o_slot_req.offset     = i_bus.addr[`TQV_OFFSET_W-1:0];
    assign o_slot_req.wdata      = i_bus.wdata;
    assign o_slot_req.write_size = i_bus.write_size;
    assign o_slot_req.read_size  = read_size_masked;

    assign o_simple_addr  = i_bus.addr[3:0];
    assign o_simple_wdata = i_bus.wdata[7:0];

    always_comb begin
        for (int k = 0; k < `TQV_USER_SLOTS; k++) begin
            user_uo[k] = user_rsp[k].uo;
        end
        for (int j = 0; j < `TQV_SIMPLE_SLOTS; j++) begin
            simple_uo[j] = i_simple_rsp[j].uo;
        end
    end

    periph_addr_decode u_decode (
        .i_bus        (i_bus),
        .i_user_rsp   (user_rsp),
        .i_simple_rsp (i_simple_rsp),
        .o_user_sel   (o_user_sel),
        .o_simple_wr  (o_simple_wr),
        .o_peri_rdata (peri_rdata),
        .o_peri_ready (peri_ready)
    );

    read_return_buffer u_rd_buf (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_read_size        (i_bus.read_size),
        .i_write_size       (i_bus.write_size),
        .i_peri_rdata       (peri_rdata),
        .i_peri_ready       (peri_ready),
        .i_read_complete    (i_read_complete),
        .o_rdata            (o_rdata),
        .o_ready            (o_ready),
        .o_read_size_masked (read_size_masked)
    );

    gpio_block u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (o_user_sel[`TQV_SLOT_GPIO]),
        .i_req      (o_slot_req),
        .i_ui_in    (i_ui_in),
        .o_rsp      (user_rsp[`TQV_SLOT_GPIO]),
        .o_func_sel (func_sel)
    );

    pin_func_mux u_pin_mux (
        .i_func_sel  (func_sel),
        .i_user_uo   (user_uo),
        .i_simple_uo (simple_uo),
        .o_uo_out    (o_uo_out)
    );

endmodule

`default_nettype wire

/* tqv_periph_params.svh */
/*
 * Address map and width constants for the TinyQV peripheral interconnect.
 * Included by the package, the RTL and the testbench.
 * User slots are 64 bytes each below 0x400, simple slots are 16 bytes
 * each from 0x400 upwards.
 */
`ifndef TQV_PERIPH_PARAMS_SVH
`define TQV_PERIPH_PARAMS_SVH

// Slot counts and output pins
`define TQV_USER_SLOTS      16
`define TQV_SIMPLE_SLOTS    16
`define TQV_PINS            8

// Bus and register widths
`define TQV_ADDR_W          11
`define TQV_DATA_W          32
`define TQV_OFFSET_W        6
`define TQV_FUNC_SEL_W      5

// Fixed slot numbers
`define TQV_SLOT_GPIO       1
`define TQV_SLOT_UART       2

// GPIO register offsets inside its user slot
`define TQV_GPIO_OUT_OFS    6'h00
`define TQV_GPIO_IN_OFS     6'h04
`define TQV_GPIO_SEL_BASE   6'h20

`endif

/* tqv_periph_pkg.sv */
/*
 * Bus types shared by the peripheral interconnect and its slots.
 * Referenced by scoped name, e.g. tqv_periph_pkg::bus_req_t.
 * The size codes match the TinyQV core encoding, with 2'b11 as idle.
 */
`default_nettype none

`include "tqv_periph_params.svh"

package tqv_periph_pkg;

    // Core read/write size codes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    // Request from the core, 47 bits
    typedef struct packed {
        logic [`TQV_ADDR_W-1:0] addr;
        logic [`TQV_DATA_W-1:0] wdata;
        access_size_e           write_size;
        access_size_e           read_size;
    } bus_req_t;

    // Broadcast to all user slots, 42 bits
    // read_size is already masked while a result sits in the return buffer
    typedef struct packed {
        logic [`TQV_OFFSET_W-1:0] offset;
        logic [`TQV_DATA_W-1:0]   wdata;
        access_size_e             write_size;
        access_size_e             read_size;
    } slot_req_t;

    // Reply from a user slot, 41 bits
    typedef struct packed {
        logic [`TQV_DATA_W-1:0] rdata;
        logic                   ready;
        logic [`TQV_PINS-1:0]   uo;
    } user_rsp_t;

    // Reply from a simple slot, 16 bits
    typedef struct packed {
        logic [7:0]           rdata;
        logic [`TQV_PINS-1:0] uo;
    } simple_rsp_t;

endpackage

`default_nettype wire
